// ==== dv/uart_cmd_tb.sv ====
`timescale 1ns/1ps

module uart_cmd_tb;
  import uart_cmd_pkg::*;

  localparam int CLKS_PER_BIT  = 8;
  localparam int GAP_CYCLES    = 20;
  localparam int REPLY_TIMEOUT = 400;
  localparam int VEC_WORDS     = 256;  // five words per line.

  logic        clk;
  logic        rst_n;
  logic        c0_req;
  cmd_t        c0_cmd;
  logic        c0_ack;
  byte_t       c0_rdata;
  logic        c0_err;
  logic        c1_req;
  cmd_t        c1_cmd;
  logic        c1_ack;
  byte_t       c1_rdata;
  logic        c1_err;
  logic        tx;
  logic        rx;
  logic [1:0]  reply_mode;
  int          model_errs;
  logic [15:0] vec_mem [0:VEC_WORDS-1];
  int          n_vec;
  logic        vec_loaded;
  int          errors;
  logic        served_q [$];

  uart_cmd_top #(
    .CLKS_PER_BIT  (CLKS_PER_BIT),
    .GAP_CYCLES    (GAP_CYCLES),
    .REPLY_TIMEOUT (REPLY_TIMEOUT)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .c0_req   (c0_req),
    .c0_cmd   (c0_cmd),
    .c0_ack   (c0_ack),
    .c0_rdata (c0_rdata),
    .c0_err   (c0_err),
    .c1_req   (c1_req),
    .c1_cmd   (c1_cmd),
    .c1_ack   (c1_ack),
    .c1_rdata (c1_rdata),
    .c1_err   (c1_err),
    .tx       (tx),
    .rx       (rx)
  );

  uart_link_model #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_model (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .reply_mode (reply_mode),
    .rx         (rx),
    .frame_errs (model_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [15:0] vec_field(input int idx, input int col);
    return vec_mem[8'(5 * idx + col)];
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic run_client(input logic port, input cmd_t cmd, input byte_t exp_rdata,
                            input logic exp_err);
    logic  ack;
    byte_t rdata;
    logic  err;
    int    hold;
    @(posedge clk);
    if (port)
    begin
      c1_cmd <= cmd;
      c1_req <= 1'b1;
    end
    else
    begin
      c0_cmd <= cmd;
      c0_req <= 1'b1;
    end
    ack = 1'b0;
    while (!ack)
    begin
      @(negedge clk);
      ack   = port ? c1_ack : c0_ack;
      rdata = port ? c1_rdata : c0_rdata;
      err   = port ? c1_err : c0_err;
    end
    served_q.push_back(port);
    check_value(port ? "c1_rdata" : "c0_rdata", 16'(rdata), 16'(exp_rdata));
    check_value(port ? "c1_err" : "c0_err", 16'(err), 16'(exp_err));
    hold = int'($urandom_range(3, 0));
    repeat (hold) @(posedge clk);
    @(posedge clk);
    if (port)
      c1_req <= 1'b0;
    else
      c0_req <= 1'b0;
    while (ack)
    begin
      @(negedge clk);
      ack = port ? c1_ack : c0_ack;
    end
  endtask

  initial
  begin
    wait (vec_loaded === 1'b1);
    repeat (n_vec * (24 * CLKS_PER_BIT + GAP_CYCLES + REPLY_TIMEOUT + 100) + 40)
      @(posedge clk);
    $display("timeout: the transactions did not complete within the time budget");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int          vec_idx;
    logic [15:0] code;
    logic [15:0] mode_w;
    rst_n  <= 1'b0;
    c0_req <= 1'b0;
    c0_cmd <= '0;
    c1_req <= 1'b0;
    c1_cmd <= '0;
    reply_mode = 2'd0;
    errors     = 0;
    n_vec      = 0;
    vec_loaded = 1'b0;
    void'($urandom(467));
    for (int k = 0; k < VEC_WORDS; k++)
      vec_mem[8'(k)] = 16'hf000 | 16'(k);  // unloaded words carry their address.
    $readmemh("dv/uart_cmd_vectors.txt", vec_mem);
    while (n_vec < VEC_WORDS / 5 && vec_field(n_vec, 0) != (16'hf000 | 16'(5 * n_vec)))
      n_vec++;
    vec_loaded = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      check_value("c0_ack", 16'(c0_ack), 16'd0);
      check_value("c1_ack", 16'(c1_ack), 16'd0);
      check_value("tx", 16'(tx), 16'd1);  // line idle.
    end
    vec_idx = 0;
    while (vec_idx < n_vec)
    begin
      code       = vec_field(vec_idx, 0);
      mode_w     = vec_field(vec_idx, 2);
      reply_mode = mode_w[1:0];
      if (code == 16'h0000 || code == 16'h0001)
      begin
        run_client(code[0], vec_field(vec_idx, 1), 8'(vec_field(vec_idx, 3)),
                   vec_field(vec_idx, 4) != 16'h0000);
        vec_idx++;
      end
      else if ((code == 16'h0002 || code == 16'h0003) && vec_idx + 1 < n_vec)
      begin
        served_q.delete();
        // both requests rise on the same clock.
        fork
          run_client(1'b0, vec_field(vec_idx, 1), 8'(vec_field(vec_idx, 3)),
                     vec_field(vec_idx, 4) != 16'h0000);
          run_client(1'b1, vec_field(vec_idx + 1, 1), 8'(vec_field(vec_idx + 1, 3)),
                     vec_field(vec_idx + 1, 4) != 16'h0000);
        join
        check_value("first_ack_port", 16'(served_q[0]), 16'(code[0]));
        vec_idx += 2;
      end
      else
      begin
        errors++;
        $display("vector line %0d has an unknown port code %h", vec_idx, code);
        vec_idx++;
      end
    end
    repeat (20) @(posedge clk);
    $display("errors: %0d value or vector, %0d command frame format", errors, model_errs);
    if (errors == 0 && model_errs == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== dv/uart_cmd_vectors.txt ====
// port cmd mode rdata err. port 2 or 3 runs this line on c0 and the next on c1 at once,
// 2 expects c0 acked first, 3 expects c1. mode 0 good reply, 1 bad parity, 2 no reply.
2 903c 0 00 0
1 91c3 0 00 0
0 8555 0 00 0
1 0500 0 55 0
1 87aa 0 00 0
0 0700 0 aa 0
0 1000 0 3c 0
1 1100 0 c3 0
0 2200 0 00 0
1 7f00 0 00 0
0 0700 1 aa 1
1 0500 0 55 0
1 0500 2 00 1
0 0700 0 aa 0
3 9a01 0 00 0
1 9bfe 0 00 0
3 1a00 0 01 0
1 1b00 0 fe 0
1 ff80 0 00 0
2 7f00 0 80 0
1 2200 0 00 0

// ==== dv/uart_link_model.sv ====
`timescale 1ns/1ps

module uart_link_model #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx,
  input  logic [1:0] reply_mode,
  output logic       rx,
  output int         frame_errs
);

  logic [7:0] regs [0:127];

  task automatic get_frame(output logic [7:0] data);
    logic par;
    logic stop;
    data = 8'h00;
    repeat (CLKS_PER_BIT / 2) @(posedge clk);  // middle of start bit.
    repeat (8)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data = {tx, data[7:1]};  // lsb arrives first.
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(posedge clk);
    stop = tx;
    if (par !== ~^data)
    begin
      frame_errs++;
      $display("model: command byte %h arrived with a wrong parity bit at %0t", data, $time);
    end
    if (stop !== 1'b1)
    begin
      frame_errs++;
      $display("model: command byte %h arrived without a stop bit at %0t", data, $time);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_par);
    logic [9:0] bits;
    bits = {1'b1, (~^data) ^ bad_par, data};
    @(posedge clk);
    rx <= 1'b0;
    repeat (10)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      rx <= bits[0];
      bits = bits >> 1;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  initial
  begin
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [15:0] word;
    rx <= 1'b1;
    frame_errs = 0;
    for (int k = 0; k < 128; k++)
      regs[7'(k)] = 8'h00;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      get_frame(lo);
      @(negedge tx);
      get_frame(hi);
      word = {hi, lo};
      if (word[15])
        regs[word[14:8]] = word[7:0];
      else if (reply_mode != 2'd2)
      begin
        repeat (2 * CLKS_PER_BIT) @(posedge clk);  // turnaround.
        send_frame(regs[word[14:8]], reply_mode == 2'd1);
      end
    end
  end

endmodule

// ==== logic/cmd_arbiter.sv ====
`timescale 1ns/1ps

module cmd_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                c0_req,
  input  uart_cmd_pkg::cmd_t  c0_cmd,
  output logic                c0_ack,
  output uart_cmd_pkg::byte_t c0_rdata,
  output logic                c0_err,
  input  logic                c1_req,
  input  uart_cmd_pkg::cmd_t  c1_cmd,
  output logic                c1_ack,
  output uart_cmd_pkg::byte_t c1_rdata,
  output logic                c1_err,
  cmd_bus_if.host             bus
);

  logic grant_vld;
  logic grant_idx;
  logic last_served;
  logic sel_req;
  logic bus_idle;
  logic pick;

  assign sel_req  = grant_idx ? c1_req : c0_req;
  assign bus_idle = !bus.req && !bus.ack;

  // on a tie the port not served last wins.
  assign pick = (c0_req && c1_req) ? !last_served : c1_req;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grant_vld   <= 1'b0;
      grant_idx   <= 1'b0;
      last_served <= 1'b1;  // port 0 first.
    end
    else if (!grant_vld)
    begin
      if (bus_idle && (c0_req || c1_req))
      begin
        grant_vld   <= 1'b1;
        grant_idx   <= pick;
        last_served <= pick;
      end
    end
    else if (!sel_req && !bus.ack)
    begin
      grant_vld <= 1'b0;  // handshake fully closed.
    end
  end

  assign bus.req = grant_vld && sel_req;
  assign bus.cmd = grant_idx ? c1_cmd : c0_cmd;

  assign c0_ack   = grant_vld && !grant_idx && bus.ack;
  assign c0_rdata = (grant_vld && !grant_idx) ? bus.rdata : '0;
  assign c0_err   = grant_vld && !grant_idx && bus.err;

  assign c1_ack   = grant_vld && grant_idx && bus.ack;
  assign c1_rdata = (grant_vld && grant_idx) ? bus.rdata : '0;
  assign c1_err   = grant_vld && grant_idx && bus.err;

endmodule

// ==== logic/cmd_bus_if.sv ====
`timescale 1ns/1ps

interface cmd_bus_if;
  import uart_cmd_pkg::*;

  logic  req;
  logic  ack;
  cmd_t  cmd;
  byte_t rdata;
  logic  err;

  modport host (
    output req,
    output cmd,
    input  ack,
    input  rdata,
    input  err
  );

  modport engine (
    input  req,
    input  cmd,
    output ack,
    output rdata,
    output err
  );

endinterface

// ==== logic/uart_cmd_engine.sv ====
`timescale 1ns/1ps

module uart_cmd_engine #(
  parameter int CLKS_PER_BIT  = 16,
  parameter int GAP_CYCLES    = 32,
  parameter int REPLY_TIMEOUT = 800
) (
  input  logic                clk,
  input  logic                rst_n,
  cmd_bus_if.engine           bus,
  output logic                tx_start,
  output uart_cmd_pkg::byte_t tx_data,
  input  logic                tx_busy,
  input  logic                rx_valid,
  input  uart_cmd_pkg::byte_t rx_data,
  input  logic                rx_parity_err,
  input  logic                rx_active
);
  import uart_cmd_pkg::*;

  localparam int CNT_MAX = (GAP_CYCLES > REPLY_TIMEOUT) ? GAP_CYCLES : REPLY_TIMEOUT;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  engine_state_t    state;
  logic             req_d;
  cmd_t             cmd_q;
  logic [CNT_W-1:0] cnt;  // gap and reply timeout.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      req_d     <= 1'b0;
      cmd_q     <= '0;
      cnt       <= '0;
      tx_start  <= 1'b0;
      tx_data   <= '0;
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
      bus.err   <= 1'b0;
    end
    else
    begin
      req_d    <= bus.req;
      tx_start <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (bus.req && !req_d)
          begin
            cmd_q    <= bus.cmd;
            tx_data  <= bus.cmd[7:0];  // low byte first.
            tx_start <= 1'b1;
            cnt      <= '0;
            state    <= S_SEND_LO;
          end
        end
        S_SEND_LO, S_SEND_HI:
        begin
          if (!tx_start && !tx_busy)
          begin
            if (state == S_SEND_LO)
            begin
              state <= S_GAP;
            end
            else if (cmd_q[CMD_WR_BIT])
            begin
              bus.rdata <= '0;
              bus.err   <= 1'b0;
              bus.ack   <= 1'b1;
              state     <= S_DONE;
            end
            else
            begin
              state <= S_WAIT_REPLY;
            end
          end
        end
        S_GAP:
        begin
          if (cnt == CNT_W'(GAP_CYCLES - 1))
          begin
            tx_data  <= cmd_q[15:8];
            tx_start <= 1'b1;
            cnt      <= '0;
            state    <= S_SEND_HI;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        S_WAIT_REPLY:
        begin
          if (rx_valid)
          begin
            bus.rdata <= rx_data;
            bus.err   <= rx_parity_err;
            bus.ack   <= 1'b1;
            state     <= S_DONE;
          end
          else if (!rx_active)
          begin
            if (cnt == CNT_W'(REPLY_TIMEOUT - 1))
            begin
              bus.rdata <= '0;
              bus.err   <= 1'b1;  // no reply.
              bus.ack   <= 1'b1;
              state     <= S_DONE;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        S_DONE:
        begin
          if (!bus.req)
          begin
            bus.ack <= 1'b0;
            state   <= S_IDLE;
          end
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // {write flag, register address[6:0], write data[7:0]}.
  typedef logic [15:0] cmd_t;

  typedef logic [7:0] byte_t;

  localparam int CMD_WR_BIT = 15;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LO,
    S_GAP,
    S_SEND_HI,
    S_WAIT_REPLY,
    S_DONE
  } engine_state_t;

  // parity bit that makes the ones count of data plus parity odd.
  function automatic logic odd_parity(input byte_t d);
    return ~^d;
  endfunction

endpackage

// ==== logic/uart_cmd_top.sv ====
`timescale 1ns/1ps

module uart_cmd_top #(
  parameter int CLKS_PER_BIT  = 16,
  parameter int GAP_CYCLES    = 32,
  parameter int REPLY_TIMEOUT = 800
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                c0_req,
  input  uart_cmd_pkg::cmd_t  c0_cmd,
  output logic                c0_ack,
  output uart_cmd_pkg::byte_t c0_rdata,
  output logic                c0_err,
  input  logic                c1_req,
  input  uart_cmd_pkg::cmd_t  c1_cmd,
  output logic                c1_ack,
  output uart_cmd_pkg::byte_t c1_rdata,
  output logic                c1_err,
  output logic                tx,
  input  logic                rx
);
  import uart_cmd_pkg::*;

  logic  tx_start;
  byte_t tx_data;
  logic  tx_busy;
  logic  rx_valid;
  byte_t rx_data;
  logic  rx_parity_err;
  logic  rx_active;

  cmd_bus_if i_bus ();

  cmd_arbiter i_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .c0_req   (c0_req),
    .c0_cmd   (c0_cmd),
    .c0_ack   (c0_ack),
    .c0_rdata (c0_rdata),
    .c0_err   (c0_err),
    .c1_req   (c1_req),
    .c1_cmd   (c1_cmd),
    .c1_ack   (c1_ack),
    .c1_rdata (c1_rdata),
    .c1_err   (c1_err),
    .bus      (i_bus.host)
  );

  uart_cmd_engine #(
    .CLKS_PER_BIT  (CLKS_PER_BIT),
    .GAP_CYCLES    (GAP_CYCLES),
    .REPLY_TIMEOUT (REPLY_TIMEOUT)
  ) i_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (i_bus.engine),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .tx_busy       (tx_busy),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_active     (rx_active)
  );

  uart_frame_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_frame_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_active     (rx_active)
  );

endmodule

// ==== logic/uart_frame_rx.sv ====
`timescale 1ns/1ps

module uart_frame_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output logic                rx_valid,
  output uart_cmd_pkg::byte_t rx_data,
  output logic                rx_parity_err,
  output logic                rx_active
);
  import uart_cmd_pkg::*;

  localparam int DIV_W = $clog2(CLKS_PER_BIT + 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_idx;
  byte_t            data_sh;
  logic             par_q;
  logic             mid_bit;
  logic             bit_end;

  assign mid_bit = (div_cnt == DIV_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end = (div_cnt == DIV_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_valid      <= 1'b0;
      rx_data       <= '0;
      rx_parity_err <= 1'b0;
      rx_active     <= 1'b0;
      div_cnt       <= '0;
      bit_idx       <= '0;
      data_sh       <= '0;
      par_q         <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (!rx_active)
      begin
        if (rx_prev && !rx_sync)
        begin
          rx_active <= 1'b1;  // falling start edge.
          div_cnt   <= '0;
          bit_idx   <= '0;
        end
      end
      else
      begin
        div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
        if (bit_end)
          bit_idx <= bit_idx + 1'b1;
        if (bit_end && bit_idx == 4'd10)
          rx_active <= 1'b0;
        if (mid_bit)
        begin
          case (bit_idx)
            4'd0:
            begin
              if (rx_sync)
                rx_active <= 1'b0;  // glitch, not a start bit.
            end
            4'd9:
              par_q <= rx_sync;
            4'd10:
            begin
              rx_valid      <= 1'b1;
              rx_data       <= data_sh;
              // bad stop bit counts as a parity error.
              rx_parity_err <= (par_q != odd_parity(data_sh)) || !rx_sync;
            end
            default:
              data_sh <= {rx_sync, data_sh[7:1]};
          endcase
        end
      end
    end
  end

endmodule

// ==== logic/uart_frame_tx.sv ====
`timescale 1ns/1ps

module uart_frame_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_cmd_pkg::byte_t tx_data,
  output logic                tx_busy,
  output logic                tx
);
  import uart_cmd_pkg::*;

  localparam int DIV_W = $clog2(CLKS_PER_BIT + 1);

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 parity, 10 stop.
  logic [9:0]       shreg;
  logic             bit_end;

  assign bit_end = (div_cnt == DIV_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      div_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;  // start bit.
        div_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      div_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // data LSB first, then parity, then stop.
  always_ff @(posedge clk)
  begin
    if (!tx_busy && tx_start)
      shreg <= {1'b1, odd_parity(tx_data), tx_data};
    else if (tx_busy && bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the uart_cmd testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module uart_cmd_tb -f uart_cmd_top.f -o sim_uart_cmd
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_uart_cmd)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation finished: PASS$'; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== uart_cmd_top.f ====
logic/uart_cmd_pkg.sv
logic/cmd_bus_if.sv
logic/cmd_arbiter.sv
logic/uart_frame_tx.sv
logic/uart_frame_rx.sv
logic/uart_cmd_engine.sv
logic/uart_cmd_top.sv
dv/uart_link_model.sv
dv/uart_cmd_tb.sv
